// File: src/st_sink_settings.svh
//--------------------------------------------------------------------------
// stream capture settings
// field widths of one sink beat, capture FIFO sizing, the ready latency
// and the geometry of the Wishbone register port
//--------------------------------------------------------------------------

`ifndef ST_SINK_SETTINGS_SVH
`define ST_SINK_SETTINGS_SVH

// sink beat geometry
`define ST_SYMBOL_W      8
`define ST_NUMSYMBOLS    4
`define ST_CHANNEL_W     4
`define ST_ERROR_W       2
// number of empty symbols in an end of packet beat
`define ST_EMPTY_W       2

// idle count per beat, saturates at all ones
`define ST_IDLE_W        16

// capture FIFO, depth is 2**ST_FIFO_AW so the pointers wrap by themselves
`define ST_FIFO_DEPTH    16
`define ST_FIFO_AW       4

// cycles from sink_ready to the beat it admits, 0 or 1 only
`define ST_READY_LATENCY 1

// Wishbone register port, word addressed
`define WB_DATA_W        32
`define WB_ADDR_W        3

`endif

// File: src/st_beat_pkg.sv
//--------------------------------------------------------------------------
// stream beat types
// field types of one Avalon-ST beat and the packed record that the
// capture FIFO holds per accepted beat
//--------------------------------------------------------------------------

`include "st_sink_settings.svh"

package st_beat_pkg;

   // one beat carries ST_NUMSYMBOLS symbols
   typedef logic [`ST_SYMBOL_W*`ST_NUMSYMBOLS-1:0] st_data_t;
   typedef logic [`ST_CHANNEL_W-1:0]               st_channel_t;
   typedef logic [`ST_ERROR_W-1:0]                 st_error_t;
   typedef logic [`ST_EMPTY_W-1:0]                 st_empty_t;
   typedef logic [`ST_IDLE_W-1:0]                  st_idle_t;

   // occupancy needs one bit above the address to reach full
   typedef logic [`ST_FIFO_AW:0]                   st_level_t;

   // captured beat
   // idles counts the qualified idle cycles seen before this beat
   typedef struct packed {
      logic        sop;
      logic        eop;
      st_channel_t channel;
      st_error_t   error;
      st_empty_t   empty;
      st_data_t    data;
      st_idle_t    idles;
   } st_beat_t;

endpackage

// File: src/wb_reg_pkg.sv
//--------------------------------------------------------------------------
// capture register map
// Wishbone word addresses, register field positions and slave states
//--------------------------------------------------------------------------

`include "st_sink_settings.svh"

package wb_reg_pkg;

   // word addresses, decoded as register opcodes
   typedef enum logic [`WB_ADDR_W-1:0] {
      REG_CTRL   = 0,
      REG_STATUS = 1,
      REG_DATA   = 2,
      REG_INFO   = 3,
      REG_IDLES  = 4,
      REG_POP    = 5
   } wb_reg_e;

   // field positions, level and idles sit at bit 0
   localparam int unsigned CTRL_READY_EN_BIT = 0;
   localparam int unsigned STATUS_EMPTY_BIT  = 8;
   localparam int unsigned INFO_SOP_BIT      = 0;
   localparam int unsigned INFO_EOP_BIT      = 1;
   localparam int unsigned INFO_CHANNEL_LSB  = 4;
   localparam int unsigned INFO_ERROR_LSB    = 8;
   localparam int unsigned INFO_EMPTY_LSB    = 12;

   // one request, one ack
   typedef enum logic {WB_IDLE, WB_ACK} wb_state_e;

endpackage

// File: src/beat_fifo_if.sv
//--------------------------------------------------------------------------
// beat FIFO bus
// carries captured beats into the FIFO and the head entry, occupancy and
// pop between the FIFO and the register side
//--------------------------------------------------------------------------

`timescale 1ns/1ps

interface beat_fifo_if;
   import st_beat_pkg::*;

   // capture side, one push per accepted beat
   logic      push;
   st_beat_t  wr_beat;

   // register side, pop removes the head
   logic      pop;

   // FIFO state, head is only meaningful while not empty
   st_beat_t  head;
   st_level_t level;
   logic      empty;

   // level feeds the ready rule on the capture side
   modport writer (
      output push,
      output wr_beat,
      input  level
   );

   modport reader (
      output pop,
      input  head,
      input  level,
      input  empty
   );

   modport fifo (
      input  push,
      input  wr_beat,
      input  pop,
      output head,
      output level,
      output empty
   );

endinterface

// File: src/st_sink_capture.sv
//--------------------------------------------------------------------------
// Avalon-ST sink capture
// drives sink_ready from the control bit and FIFO level, qualifies beats
// by the ready latency, counts idle cycles and pushes each accepted beat
// together with its idle count into the capture FIFO
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "st_sink_settings.svh"

module st_sink_capture (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ready_en,
   input  st_beat_pkg::st_data_t    sink_data,
   input  st_beat_pkg::st_channel_t sink_channel,
   input  logic                     sink_valid,
   input  logic                     sink_startofpacket,
   input  logic                     sink_endofpacket,
   input  st_beat_pkg::st_error_t   sink_error,
   input  st_beat_pkg::st_empty_t   sink_empty,
   output logic                     sink_ready,
   beat_fifo_if.writer              fifo
);
   import st_beat_pkg::*;

   logic     ready_d1;
   logic     ready_q;
   logic     accept;
   st_idle_t idle_cnt;

   //--------------------------------------------------------------------------
   // back-pressure
   //--------------------------------------------------------------------------

   // keep room for the beat that may still arrive one cycle after ready
   // drops, level and ready_en are both registered
   assign sink_ready = ready_en &&
      (int'(fifo.level) + `ST_READY_LATENCY < `ST_FIFO_DEPTH);

   // ready as seen by the source one cycle ago
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_d1 <= 1'b0;
      end else begin
         ready_d1 <= sink_ready;
      end
   end

   // qualified ready, the ready that admits the beat on the pins now
   assign ready_q = (`ST_READY_LATENCY == 0) ? sink_ready : ready_d1;
   assign accept  = ready_q && sink_valid;

   //--------------------------------------------------------------------------
   // idle counting
   //--------------------------------------------------------------------------

   // an accepted beat takes the old count, the counter restarts at zero
   // without an accept, a qualified ready cycle is an idle cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idle_cnt <= '0;
      end else if (accept) begin
         idle_cnt <= '0;
      end else if (ready_q && (idle_cnt != '1)) begin
         idle_cnt <= idle_cnt + 1'b1;
      end
   end

   //--------------------------------------------------------------------------
   // beat assembly
   //--------------------------------------------------------------------------

   // the FIFO writes on the acceptance edge itself
   assign fifo.push    = accept;
   assign fifo.wr_beat = '{
      sop:     sink_startofpacket,
      eop:     sink_endofpacket,
      channel: sink_channel,
      error:   sink_error,
      empty:   sink_empty,
      data:    sink_data,
      idles:   idle_cnt
   };

   // the margin in the ready rule must keep a full FIFO away from the pins
   a_no_accept_when_full: assert property (
      @(posedge clk) disable iff (reset)
      accept |-> (int'(fifo.level) < `ST_FIFO_DEPTH)
   );

endmodule

// File: src/beat_fifo.sv
//--------------------------------------------------------------------------
// beat FIFO
// circular buffer of captured beats with read and write pointers and an
// occupancy count, head is shown combinationally from the read pointer
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "st_sink_settings.svh"

module beat_fifo (
   input logic       clk,
   input logic       reset,
   beat_fifo_if.fifo port
);
   import st_beat_pkg::*;

   localparam st_level_t FULL_LEVEL = st_level_t'(`ST_FIFO_DEPTH);

   st_beat_t               mem [`ST_FIFO_DEPTH];
   logic [`ST_FIFO_AW-1:0] wr_ptr;
   logic [`ST_FIFO_AW-1:0] rd_ptr;
   st_level_t              count;
   logic                   full;
   logic                   do_push;
   logic                   do_pop;

   assign full    = (count == FULL_LEVEL);
   // a pop on an empty FIFO is dropped
   assign do_push = port.push && !full;
   assign do_pop  = port.pop && (count != '0);

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= port.wr_beat;
      end
   end

   // pointers wrap naturally at 2**ST_FIFO_AW
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // push and pop together keep the count
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign port.head  = mem[rd_ptr];
   assign port.level = count;
   assign port.empty = (count == '0);

   // the writer throttles through sink_ready, so a full push is a bug there
   a_no_push_when_full: assert property (
      @(posedge clk) disable iff (reset)
      port.push |-> !full
   );

endmodule

// File: src/wb_regs.sv
//--------------------------------------------------------------------------
// capture registers
// Wishbone classic slave with a registered ack, holds the ready enable,
// exposes FIFO status and the head beat, and pops the head on request
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "st_sink_settings.svh"

module wb_regs (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`WB_ADDR_W-1:0] wb_adr,
   input  logic [`WB_DATA_W-1:0] wb_dat_w,
   output logic [`WB_DATA_W-1:0] wb_dat_r,
   output logic                  wb_ack,
   output logic                  ready_en,
   beat_fifo_if.reader           fifo
);
   import wb_reg_pkg::*;

   wb_state_e             state;
   wb_reg_e               reg_sel;
   logic                  req;
   logic                  wr_ack;
   logic [`WB_DATA_W-1:0] rd_data;

   assign req     = wb_cyc && wb_stb;
   assign reg_sel = wb_reg_e'(wb_adr);

   // the master holds adr, we and data through the ack cycle
   // so writes commit on the ack edge
   assign wr_ack = (state == WB_ACK) && req && wb_we;

   //--------------------------------------------------------------------------
   // bus FSM
   //--------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= WB_IDLE;
      end else begin
         case (state)
            WB_IDLE: begin
               if (req) begin
                  state <= WB_ACK;
               end
            end
            // the master drops stb after ack so the slave returns to idle
            WB_ACK:  state <= WB_IDLE;
            default: state <= WB_IDLE;
         endcase
      end
   end

   assign wb_ack = (state == WB_ACK);

   //--------------------------------------------------------------------------
   // control and pop
   //--------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_en <= 1'b0;
      end else if (wr_ack && (reg_sel == REG_CTRL)) begin
         ready_en <= wb_dat_w[CTRL_READY_EN_BIT];
      end
   end

   // one cycle wide pulse that removes the head on the ack edge
   assign fifo.pop = wr_ack && (reg_sel == REG_POP);

   //--------------------------------------------------------------------------
   // read path
   //--------------------------------------------------------------------------

   // unmapped and write only addresses read as zero
   always_comb begin
      rd_data = '0;
      case (reg_sel)
         REG_CTRL: rd_data[CTRL_READY_EN_BIT] = ready_en;
         REG_STATUS: begin
            rd_data[`ST_FIFO_AW:0]     = fifo.level;
            rd_data[STATUS_EMPTY_BIT]  = fifo.empty;
         end
         REG_DATA: rd_data[`ST_SYMBOL_W*`ST_NUMSYMBOLS-1:0] = fifo.head.data;
         REG_INFO: begin
            rd_data[INFO_SOP_BIT]                    = fifo.head.sop;
            rd_data[INFO_EOP_BIT]                    = fifo.head.eop;
            rd_data[INFO_CHANNEL_LSB +: `ST_CHANNEL_W] = fifo.head.channel;
            rd_data[INFO_ERROR_LSB +: `ST_ERROR_W]     = fifo.head.error;
            rd_data[INFO_EMPTY_LSB +: `ST_EMPTY_W]     = fifo.head.empty;
         end
         REG_IDLES: rd_data[`ST_IDLE_W-1:0] = fifo.head.idles;
         default:   rd_data = '0;
      endcase
   end

   // sampled with the request and presented during the ack cycle
   always_ff @(posedge clk) begin
      if ((state == WB_IDLE) && req) begin
         wb_dat_r <= rd_data;
      end
   end

   // writes and pops commit on the ack edge and need the request still standing
   a_req_held_at_ack: assert property (
      @(posedge clk) disable iff (reset)
      wb_ack |-> (req && $stable(wb_adr) && $stable(wb_we))
   );

endmodule

// File: src/st_capture_top.sv
//--------------------------------------------------------------------------
// stream capture top
// Avalon-ST sink in, Wishbone classic register port out, capture logic,
// beat FIFO and register slave joined over one FIFO bus
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "st_sink_settings.svh"

module st_capture_top (
   input  logic                     clk,
   input  logic                     reset,
   // Avalon-ST sink
   input  st_beat_pkg::st_data_t    sink_data,
   input  st_beat_pkg::st_channel_t sink_channel,
   input  logic                     sink_valid,
   input  logic                     sink_startofpacket,
   input  logic                     sink_endofpacket,
   input  st_beat_pkg::st_error_t   sink_error,
   input  st_beat_pkg::st_empty_t   sink_empty,
   output logic                     sink_ready,
   // Wishbone classic slave
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [`WB_ADDR_W-1:0]    wb_adr,
   input  logic [`WB_DATA_W-1:0]    wb_dat_w,
   output logic [`WB_DATA_W-1:0]    wb_dat_r,
   output logic                     wb_ack
);

   // control bit from the registers to the back-pressure logic
   logic ready_en;

   beat_fifo_if fifo_bus ();

   st_sink_capture u_capture (
      .clk                (clk),
      .reset              (reset),
      .ready_en           (ready_en),
      .sink_data          (sink_data),
      .sink_channel       (sink_channel),
      .sink_valid         (sink_valid),
      .sink_startofpacket (sink_startofpacket),
      .sink_endofpacket   (sink_endofpacket),
      .sink_error         (sink_error),
      .sink_empty         (sink_empty),
      .sink_ready         (sink_ready),
      .fifo               (fifo_bus.writer)
   );

   beat_fifo u_fifo (
      .clk   (clk),
      .reset (reset),
      .port  (fifo_bus.fifo)
   );

   wb_regs u_regs (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .ready_en (ready_en),
      .fifo     (fifo_bus.reader)
   );

endmodule

// File: tb/tb_st_capture.sv
//--------------------------------------------------------------------------
// stream capture testbench
// random Avalon-ST beats from an LFSR, a queue model of the capture FIFO
// and Wishbone register reads that compare stored beats with the model
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "st_sink_settings.svh"

module tb_st_capture;
   import st_beat_pkg::*;
   import wb_reg_pkg::*;

   localparam int LAT       = `ST_READY_LATENCY;
   localparam int DEPTH     = `ST_FIFO_DEPTH;
   localparam int ACK_LIMIT = 20;

   logic                  clk;
   logic                  reset;
   st_data_t              sink_data;
   st_channel_t           sink_channel;
   logic                  sink_valid;
   logic                  sink_startofpacket;
   logic                  sink_endofpacket;
   st_error_t             sink_error;
   st_empty_t             sink_empty;
   logic                  sink_ready;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [`WB_ADDR_W-1:0] wb_adr;
   logic [`WB_DATA_W-1:0] wb_dat_w;
   logic [`WB_DATA_W-1:0] wb_dat_r;
   logic                  wb_ack;

   // reference model state
   st_beat_t    model_q[$];
   st_idle_t    model_idles;
   logic        ready_prev;
   logic        ctrl_model;
   logic        last_accept;
   logic [31:0] lfsr;
   logic [31:0] rd;
   int          saved_size;
   int          errors;
   int          timeouts;
   int          checks;

   st_capture_top uut (
      .clk (clk), .reset (reset),
      .sink_data (sink_data), .sink_channel (sink_channel),
      .sink_valid (sink_valid), .sink_startofpacket (sink_startofpacket),
      .sink_endofpacket (sink_endofpacket), .sink_error (sink_error),
      .sink_empty (sink_empty), .sink_ready (sink_ready),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   //--------------------------------------------------------------------------
   // helpers
   //--------------------------------------------------------------------------

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   // fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // INFO layout from the register map
   function automatic logic [31:0] info_word(input st_beat_t b);
      logic [31:0] w;
      w = '0;
      w[0] = b.sop;
      w[1] = b.eop;
      w[7:4] = b.channel;
      w[9:8] = b.error;
      w[13:12] = b.empty;
      return w;
   endfunction

   //--------------------------------------------------------------------------
   // model sampled at the falling edge where pins and ready are settled
   //--------------------------------------------------------------------------

   always @(negedge clk) begin : model_step
      logic     q_ready;
      st_beat_t beat;
      if (reset) begin
         model_q.delete();
         model_idles = '0;
         ready_prev  = 1'b0;
         last_accept = 1'b0;
      end else begin
         // ready needs level plus latency below the depth
         check(sink_ready, ctrl_model && (model_q.size() + LAT < DEPTH), "sink_ready");
         q_ready = (LAT == 0) ? sink_ready : ready_prev;
         last_accept = q_ready && sink_valid;
         if (last_accept) begin
            beat.sop     = sink_startofpacket;
            beat.eop     = sink_endofpacket;
            beat.channel = sink_channel;
            beat.error   = sink_error;
            beat.empty   = sink_empty;
            beat.data    = sink_data;
            beat.idles   = model_idles;
            model_q.push_back(beat);
            model_idles = '0;
         end else if (q_ready && (model_idles != '1)) begin
            model_idles = model_idles + 1'b1;
         end
         check(model_q.size() <= DEPTH, 1, "model level bound");
         ready_prev = sink_ready;
      end
   end

   //--------------------------------------------------------------------------
   // Wishbone master
   //--------------------------------------------------------------------------

   task automatic wb_access(input logic [2:0] adr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      @(posedge clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      n = 0;
      @(negedge clk);
      while (!wb_ack && n < ACK_LIMIT) begin
         @(negedge clk);
         n++;
      end
      rdata = wb_dat_r;
      if (!wb_ack) begin
         timeouts++;
         $display("timeout: no wb_ack for the access to address %0d", adr);
      end else begin
         // ack follows the sampled request by exactly one cycle
         check(n, 1, "wb_ack latency");
      end
      // request held through the ack edge and released after it
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdata);
      wb_access(adr, 1'b0, 32'h0, rdata);
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdata);
      logic [31:0] unused;
      wb_access(adr, 1'b1, wdata, unused);
   endtask

   //--------------------------------------------------------------------------
   // stream source and register checks
   //--------------------------------------------------------------------------

   task automatic new_beat();
      sink_data          = rand_bits(32);
      sink_channel       = rand_bits(4);
      sink_startofpacket = rand_bits(1);
      sink_endofpacket   = rand_bits(1);
      sink_error         = rand_bits(2);
      sink_empty         = rand_bits(2);
   endtask

   task automatic drive_stream(input int cycles, input logic always_valid);
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk);
         #1;
         // a refused beat stays on the pins until accepted
         if (!sink_valid || last_accept) begin
            new_beat();
            sink_valid = always_valid || (rand_bits(2) != 2'b00);
         end
      end
   endtask

   task automatic stop_stream();
      @(posedge clk);
      #1;
      sink_valid = 1'b0;
      repeat (2) @(posedge clk);
   endtask

   task automatic check_status();
      logic [31:0] rdata;
      logic [31:0] exp;
      exp = '0;
      exp[4:0] = model_q.size();
      exp[8] = (model_q.size() == 0);
      wb_read(REG_STATUS, rdata);
      check(rdata, exp, "STATUS");
      check(rdata[4:0] <= DEPTH, 1, "STATUS level bound");
   endtask

   // read, compare and pop every head beat
   task automatic drain();
      logic [31:0] rdata;
      st_beat_t    exp;
      int          guard;
      guard = 0;
      while (model_q.size() > 0 && guard < 2 * DEPTH) begin
         exp = model_q[0];
         wb_read(REG_DATA, rdata);
         check(rdata, exp.data, "DATA");
         wb_read(REG_INFO, rdata);
         check(rdata, info_word(exp), "INFO");
         wb_read(REG_IDLES, rdata);
         check(rdata, 32'(exp.idles), "IDLES");
         wb_write(REG_POP, 32'h0);
         void'(model_q.pop_front());
         guard++;
      end
      check_status();
   endtask

   task automatic wait_ready_low();
      int n;
      n = 0;
      while (sink_ready && n < ACK_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (sink_ready) begin
         timeouts++;
         $display("timeout: sink_ready stayed high after ready_en was cleared");
      end
   endtask

   //--------------------------------------------------------------------------
   // test sequence
   //--------------------------------------------------------------------------

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      sink_data = '0;
      sink_channel = '0;
      sink_valid = 1'b0;
      sink_startofpacket = 1'b0;
      sink_endofpacket = 1'b0;
      sink_error = '0;
      sink_empty = '0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      lfsr = 32'ha6ab;
      ctrl_model = 1'b0;
      last_accept = 1'b0;
      errors = 0;
      timeouts = 0;
      checks = 0;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;

      // nothing is captured while disabled after reset
      wb_read(REG_CTRL, rd);
      check(rd, 32'h0, "CTRL after reset");
      check_status();
      drive_stream(24, 1'b0);
      stop_stream();
      check_status();

      // random valid beats read back and popped in order
      wb_write(REG_CTRL, 32'h1);
      ctrl_model = 1'b1;
      repeat (3) begin
         drive_stream(20, 1'b0);
         stop_stream();
         check_status();
         drain();
      end

      // continuous valid without pops fills the FIFO exactly
      drive_stream(40, 1'b1);
      stop_stream();
      check_status();
      check(model_q.size(), DEPTH, "level after fill");
      drain();

      // pop on an empty FIFO
      wb_write(REG_POP, 32'h0);
      check_status();

      // clearing ready_en stops capture
      drive_stream(6, 1'b0);
      stop_stream();
      wb_write(REG_CTRL, 32'h0);
      ctrl_model = 1'b0;
      wait_ready_low();
      saved_size = model_q.size();
      drive_stream(20, 1'b0);
      stop_stream();
      check(model_q.size(), saved_size, "queue size while disabled");
      check_status();
      drain();

      $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+src
src/st_beat_pkg.sv
src/wb_reg_pkg.sv
src/beat_fifo_if.sv
src/st_sink_capture.sv
src/beat_fifo.sv
src/wb_regs.sv
src/st_capture_top.sv
tb/tb_st_capture.sv
